// File: files.f
src/cce_cache_pkg.sv
src/msg_fifo.sv
src/cache_cmd_ctrl.sv
src/cache_pkt_encode.sv
src/resp_collect.sv
src/cce_to_cache.sv
testbench/cache_model.sv
testbench/cce_to_cache_assertions.sv
testbench/cce_to_cache_tb.sv

// File: testbench/cce_to_cache_tb.sv
// 4 sets by 2 ways; every address stays below 0x200 and aligned to its size
`timescale 1ns/1ps

module cce_to_cache_tb
  import cce_cache_pkg::*;
();

  localparam int SETS = 4;
  localparam int WAYS = 2;
  localparam int TAG_TOTAL = SETS * WAYS;
  localparam int NUM_TESTS = 14;
  localparam int SB_WORDS = 64;
  localparam int CLK_PERIOD = 4;
  localparam int RESET_CYCLES = 10;
  // two cycles per tag store through the model, doubled for margin
  localparam int CLEAR_CYCLES = 4 * TAG_TOTAL + 8;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + CLEAR_CYCLES + 200 * NUM_TESTS;

  typedef struct packed {
    mem_msg_type_e msg_type;
    mem_msg_size_e size;
    logic [ADDR_W-1:0] addr;
    cache_op_e exp_op;
    logic [BLOCK_WORDS-1:0][DATA_W-1:0] data;
    logic [BLOCK_WORDS-1:0][DATA_W-1:0] exp_data;
  } test_entry_s;

  logic clk_i = 1'b0;
  logic reset_i;
  mem_msg_s mem_cmd_i, mem_resp_o;
  logic mem_cmd_v_i, mem_cmd_ready_and_o, mem_resp_v_o, mem_resp_yumi_i;
  cache_pkt_s cache_pkt_o;
  logic cache_v_o, cache_ready_i, cache_v_i, cache_yumi_o;
  logic [DATA_W-1:0] cache_data_i;

  test_entry_s tbl [NUM_TESTS];
  logic [DATA_W-1:0] sb_mem [SB_WORDS];
  logic tag_seen [TAG_TOTAL];
  logic [31:0] lfsr_r = 32'h3af45f11;
  logic [63:0] yumi_bits;
  int mismatch_errors = 0;
  int other_errors = 0;
  int tag_count = 0;
  int pkt_entry = 0;
  int pkt_beat = 0;
  int resp_count = 0;
  logic other_seen = 1'b0;

  cce_to_cache #(.SETS_P(SETS), .WAYS_P(WAYS)) UUT (.*);

  cache_model cache (
    .clk_i(clk_i), .reset_i(reset_i), .pkt_i(cache_pkt_o), .v_i(cache_v_o),
    .ready_o(cache_ready_i), .data_o(cache_data_i), .v_o(cache_v_i), .yumi_i(cache_yumi_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  ////////////////////
  // helpers
  ////////////////////

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [63:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_r = lfsr_next(lfsr_r);
      bits = {bits[62:0], lfsr_r[0]};
    end
  endtask

  // block sizes take one 8-byte beat each
  function automatic int beats_for(mem_msg_size_e size);
    case (size)
      e_size_16: return 2;
      e_size_32: return 4;
      e_size_64: return 8;
      default: return 1;
    endcase
  endfunction

  function automatic logic [DATA_W-1:0] size_mask(mem_msg_size_e size);
    case (size)
      e_size_1: return 64'h0000_0000_0000_00ff;
      e_size_2: return 64'h0000_0000_0000_ffff;
      e_size_4: return 64'h0000_0000_ffff_ffff;
      default: return '1;
    endcase
  endfunction

  task automatic set_entry(input int i, input mem_msg_type_e t, input mem_msg_size_e s,
                           input logic [ADDR_W-1:0] a, input cache_op_e op);
    tbl[i].msg_type = t;
    tbl[i].size = s;
    tbl[i].addr = a;
    tbl[i].exp_op = op;
  endtask

  // write data from the LFSR, expected read data from the scoreboard in command order
  task automatic build_expected();
    logic [63:0] bits;
    int base;
    int n;
    // same index fill as the cache model
    for (int k = 0; k < SB_WORDS; k++) sb_mem[k] = {32'(k), ~32'(k)};
    for (int i = 0; i < NUM_TESTS; i++) begin
      base = int'(tbl[i].addr >> BYTE_OFFSET_W);
      n = beats_for(tbl[i].size);
      tbl[i].data = '0;
      tbl[i].exp_data = '0;
      for (int w = 0; w < n; w++) begin
        if (tbl[i].msg_type == e_mem_wr) begin
          take_bits(DATA_W, bits);
          tbl[i].data[w] = bits;
          sb_mem[base + w] = bits;
        end else if (n == 1) begin
          tbl[i].exp_data[w] = sb_mem[base] & size_mask(tbl[i].size);
        end else begin
          tbl[i].exp_data[w] = sb_mem[base + w];
        end
      end
    end
  endtask

  task automatic check_packet();
    int idx;
    logic [ADDR_W-1:0] exp_addr;
    if (cache_pkt_o.opcode == e_tagst) begin
      idx = int'(cache_pkt_o.addr >> BLOCK_OFFSET_W);
      if (other_seen) begin
        other_errors++;
        $display("tag store seen after command packets began");
      end else if (idx >= TAG_TOTAL || tag_seen[idx]) begin
        other_errors++;
        $display("tag store index %0d repeated or out of range", idx);
      end else begin
        tag_seen[idx] = 1'b1;
      end
      // tag stores carry no data
      if (cache_pkt_o.data != '0) begin
        mismatch_errors++;
        $display("Mismatch cache_pkt_o.data tag store %0d: got %h expected %h", idx,
                 cache_pkt_o.data, {DATA_W{1'b0}});
      end
      tag_count++;
    end else if (pkt_entry >= NUM_TESTS) begin
      other_errors++;
      $display("cache packet issued after the last command");
    end else begin
      if (!other_seen && tag_count != TAG_TOTAL) begin
        other_errors++;
        $display("only %0d tag stores before the first command packet", tag_count);
      end
      other_seen = 1'b1;
      exp_addr = tbl[pkt_entry].addr + ADDR_W'(8 * pkt_beat);
      if (cache_pkt_o.opcode != tbl[pkt_entry].exp_op) begin
        mismatch_errors++;
        $display("Mismatch cache_pkt_o.opcode cmd %0d: got %h expected %h", pkt_entry,
                 cache_pkt_o.opcode, tbl[pkt_entry].exp_op);
      end
      if (cache_pkt_o.addr != exp_addr) begin
        mismatch_errors++;
        $display("Mismatch cache_pkt_o.addr cmd %0d beat %0d: got %h expected %h",
                 pkt_entry, pkt_beat, cache_pkt_o.addr, exp_addr);
      end
      // every command beat enables all bytes
      if (cache_pkt_o.mask != {MASK_W{1'b1}}) begin
        mismatch_errors++;
        $display("Mismatch cache_pkt_o.mask cmd %0d beat %0d: got %h expected %h",
                 pkt_entry, pkt_beat, cache_pkt_o.mask, {MASK_W{1'b1}});
      end
      if (tbl[pkt_entry].msg_type == e_mem_wr &&
          cache_pkt_o.data != tbl[pkt_entry].data[pkt_beat]) begin
        mismatch_errors++;
        $display("Mismatch cache_pkt_o.data cmd %0d beat %0d: got %h expected %h",
                 pkt_entry, pkt_beat, cache_pkt_o.data, tbl[pkt_entry].data[pkt_beat]);
      end
      pkt_beat++;
      if (pkt_beat == beats_for(tbl[pkt_entry].size)) begin
        pkt_beat = 0;
        pkt_entry++;
      end
    end
  endtask

  task automatic check_response();
    mem_hdr_s exp_hdr;
    if (resp_count >= NUM_TESTS) begin
      other_errors++;
      $display("memory response after the last command");
    end else begin
      exp_hdr.msg_type = tbl[resp_count].msg_type;
      exp_hdr.size = tbl[resp_count].size;
      exp_hdr.addr = tbl[resp_count].addr;
      if (mem_resp_o.hdr != exp_hdr) begin
        mismatch_errors++;
        $display("Mismatch mem_resp_o.hdr cmd %0d: got %h expected %h", resp_count,
                 mem_resp_o.hdr, exp_hdr);
      end
      // only the words covered by the size
      for (int w = 0; w < beats_for(exp_hdr.size); w++) begin
        if (mem_resp_o.data[w] != tbl[resp_count].exp_data[w]) begin
          mismatch_errors++;
          $display("Mismatch mem_resp_o.data[%0d] cmd %0d: got %h expected %h", w,
                   resp_count, mem_resp_o.data[w], tbl[resp_count].exp_data[w]);
        end
      end
    end
    resp_count++;
  endtask

  task automatic finish_run();
    $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatch_errors, other_errors, UUT.checks.fail_count);
    if (mismatch_errors == 0 && other_errors == 0 && UUT.checks.fail_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  initial begin
    mem_msg_s cmd;
    reset_i = 1'b1;
    mem_cmd_i = '0;
    mem_cmd_v_i = 1'b0;
    mem_resp_yumi_i = 1'b0;
    for (int k = 0; k < TAG_TOTAL; k++) tag_seen[k] = 1'b0;
    // sized writes, block write and read back, sized reads, short blocks
    set_entry(0, e_mem_wr, e_size_1, 28'h100, e_sb);
    set_entry(1, e_mem_wr, e_size_2, 28'h108, e_sh);
    set_entry(2, e_mem_wr, e_size_4, 28'h110, e_sw);
    set_entry(3, e_mem_wr, e_size_8, 28'h118, e_sd);
    set_entry(4, e_mem_wr, e_size_64, 28'h140, e_sm);
    set_entry(5, e_mem_rd, e_size_64, 28'h140, e_lm);
    set_entry(6, e_mem_rd, e_size_1, 28'h100, e_lb);
    set_entry(7, e_mem_rd, e_size_2, 28'h108, e_lh);
    set_entry(8, e_mem_rd, e_size_4, 28'h110, e_lw);
    set_entry(9, e_mem_rd, e_size_8, 28'h118, e_ld);
    set_entry(10, e_mem_wr, e_size_16, 28'h180, e_sm);
    set_entry(11, e_mem_rd, e_size_32, 28'h180, e_lm);
    set_entry(12, e_mem_wr, e_size_8, 28'h100, e_sd);
    set_entry(13, e_mem_rd, e_size_16, 28'h100, e_lm);
    build_expected();
    repeat (RESET_CYCLES) @(posedge clk_i);
    reset_i <= 1'b0;
    // commands queue up while tags are cleared
    for (int i = 0; i < NUM_TESTS; i++) begin
      @(posedge clk_i);
      cmd.hdr.msg_type = tbl[i].msg_type;
      cmd.hdr.size = tbl[i].size;
      cmd.hdr.addr = tbl[i].addr;
      cmd.data = tbl[i].data;
      mem_cmd_i <= cmd;
      mem_cmd_v_i <= 1'b1;
      @(negedge clk_i);
      while (!mem_cmd_ready_and_o) @(negedge clk_i);
    end
    @(posedge clk_i);
    mem_cmd_v_i <= 1'b0;
    wait (resp_count == NUM_TESTS);
    repeat (4) @(posedge clk_i);
    if (tag_count != TAG_TOTAL) begin
      other_errors++;
      $display("saw %0d tag stores instead of %0d", tag_count, TAG_TOTAL);
    end
    finish_run();
  end

  ////////////////////
  // monitors
  ////////////////////

  always @(negedge clk_i) begin
    if (!reset_i && cache_v_o && cache_ready_i) check_packet();
  end

  // random yumi, one LFSR bit per cycle; raised only on a response seen valid
  initial begin
    forever begin
      @(negedge clk_i);
      if (mem_resp_yumi_i) check_response();
      take_bits(1, yumi_bits);
      @(posedge clk_i);
      if (!reset_i && mem_resp_v_o && !mem_resp_yumi_i && yumi_bits[0]) begin
        mem_resp_yumi_i <= 1'b1;
      end else begin
        mem_resp_yumi_i <= 1'b0;
      end
    end
  end

  // watchdog
  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    other_errors++;
    $display("timeout after %0d cycles with %0d of %0d responses", TIMEOUT_CYCLES,
             resp_count, NUM_TESTS);
    finish_run();
  end

endmodule

// File: testbench/cce_to_cache_assertions.sv
// bound into the bridge top level; one clock, synchronous active-high reset
`timescale 1ns/1ps

module cce_to_cache_assertions
  import cce_cache_pkg::*;
(
  input logic       clk_i,
  input logic       reset_i,
  input cache_pkt_s pkt_i,
  input logic       pkt_v_i,
  input logic       pkt_ready_i,
  input mem_msg_s   resp_i,
  input logic       resp_v_i,
  input logic       resp_yumi_i,
  input logic       clearing_i
);

  // failures seen so far, read by the testbench at the end
  int fail_count = 0;

  ////////////////////
  // cache packet port
  ////////////////////

  // stalled packet keeps valid and content
  a_pkt_held: assert property (@(posedge clk_i) disable iff (reset_i)
    pkt_v_i && !pkt_ready_i |=> pkt_v_i && $stable(pkt_i))
    else begin
      $error("cache packet changed while stalled");
      fail_count++;
    end

  // only tag stores during clear
  a_clear_op: assert property (@(posedge clk_i) disable iff (reset_i)
    clearing_i && pkt_v_i |-> pkt_i.opcode == e_tagst)
    else begin
      $error("non tag-store opcode during tag clear");
      fail_count++;
    end

  ////////////////////
  // memory response port
  ////////////////////

  a_resp_held: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_v_i && !resp_yumi_i |=> resp_v_i && $stable(resp_i))
    else begin
      $error("memory response dropped or changed before yumi");
      fail_count++;
    end

endmodule

bind cce_to_cache cce_to_cache_assertions checks (
  .clk_i(clk_i), .reset_i(reset_i),
  .pkt_i(cache_pkt_o), .pkt_v_i(cache_v_o), .pkt_ready_i(cache_ready_i),
  .resp_i(mem_resp_o), .resp_v_i(mem_resp_v_o), .resp_yumi_i(mem_resp_yumi_i),
  .clearing_i(clearing)
);

// File: testbench/cache_model.sv
// one outstanding packet at a time; 64-word memory indexed by addr[8:3], byte offsets ignored
`timescale 1ns/1ps

module cache_model
  import cce_cache_pkg::*;
#(
  parameter int WORDS_P = 64
) (
  input  logic              clk_i,
  input  logic              reset_i,
  input  cache_pkt_s        pkt_i,
  input  logic              v_i,
  output logic              ready_o,
  output logic [DATA_W-1:0] data_o,
  output logic              v_o,
  input  logic              yumi_i
);

  localparam int WIDX_W = $clog2(WORDS_P);

  logic [DATA_W-1:0] mem [WORDS_P];
  logic [WIDX_W-1:0] widx;
  logic [DATA_W-1:0] data_r;
  // a returned beat is waiting for yumi
  logic busy_r;

  assign widx    = pkt_i.addr[BYTE_OFFSET_W +: WIDX_W];
  assign ready_o = ~busy_r;
  assign v_o     = busy_r;
  assign data_o  = data_r;

  // loads keep only the bytes of their size
  function automatic logic [DATA_W-1:0] load_mask(cache_op_e op);
    case (op)
      e_lb: return 64'h0000_0000_0000_00ff;
      e_lh: return 64'h0000_0000_0000_ffff;
      e_lw: return 64'h0000_0000_ffff_ffff;
      default: return '1;
    endcase
  endfunction

  initial begin
    busy_r = 1'b0;
    data_r = '0;
    // unwritten words hold their own index
    for (int i = 0; i < WORDS_P; i++) mem[i] = {32'(i), ~32'(i)};
  end

  always @(posedge clk_i) begin
    if (reset_i) begin
      busy_r <= 1'b0;
    end else if (busy_r) begin
      if (yumi_i) busy_r <= 1'b0;
    end else if (v_i) begin
      busy_r <= 1'b1;
      case (pkt_i.opcode)
        // stores write the whole word and answer zero
        e_sb, e_sh, e_sw, e_sd, e_sm: begin
          mem[widx] <= pkt_i.data;
          data_r    <= '0;
        end
        e_tagst: data_r <= '0;
        default: data_r <= mem[widx] & load_mask(pkt_i.opcode);
      endcase
    end
  end

endmodule

// File: src/cce_to_cache.sv
// tags are cleared after each reset before commands are taken; cache must return one beat per packet
`timescale 1ns/1ps

module cce_to_cache
  import cce_cache_pkg::*;
#(
  parameter int SETS_P = 64,
  parameter int WAYS_P = 8
) (
  input  logic              clk_i,
  input  logic              reset_i,
  // memory command
  input  mem_msg_s          mem_cmd_i,
  input  logic              mem_cmd_v_i,
  output logic              mem_cmd_ready_and_o,
  // memory response
  output mem_msg_s          mem_resp_o,
  output logic              mem_resp_v_o,
  input  logic              mem_resp_yumi_i,
  // cache packet
  output cache_pkt_s        cache_pkt_o,
  output logic              cache_v_o,
  input  logic              cache_ready_i,
  // cache data
  input  logic [DATA_W-1:0] cache_data_i,
  input  logic              cache_v_i,
  output logic              cache_yumi_o
);

  localparam int IDX_W = $clog2(SETS_P * WAYS_P);

  mem_msg_s cmd;
  mem_hdr_s hdr;
  ctrl_state_e state;
  logic [BEAT_CNT_W-1:0] beat;
  logic [IDX_W-1:0] tag_idx;
  logic cmd_v, cmd_yumi, hdr_push, hdr_ready, hdr_v, clearing;

  ////////////////////
  // command side
  ////////////////////

  msg_fifo #(.WIDTH_P($bits(mem_msg_s)), .DEPTH_P(4)) cmd_fifo (
    .clk_i(clk_i), .reset_i(reset_i),
    .data_i(mem_cmd_i), .v_i(mem_cmd_v_i), .ready_o(mem_cmd_ready_and_o),
    .data_o(cmd), .v_o(cmd_v), .yumi_i(cmd_yumi)
  );

  cache_cmd_ctrl #(.SETS_P(SETS_P), .WAYS_P(WAYS_P)) ctrl (
    .clk_i(clk_i), .reset_i(reset_i),
    .cmd_i(cmd), .cmd_v_i(cmd_v), .hdr_ready_i(hdr_ready),
    .cache_ready_i(cache_ready_i), .cache_v_i(cache_v_i),
    .cmd_yumi_o(cmd_yumi), .hdr_v_o(hdr_push), .state_o(state),
    .beat_o(beat), .tag_idx_o(tag_idx), .cache_v_o(cache_v_o), .clearing_o(clearing)
  );

  cache_pkt_encode #(.SETS_P(SETS_P), .WAYS_P(WAYS_P)) encode (
    .state_i(state), .cmd_i(cmd), .beat_i(beat), .tag_idx_i(tag_idx), .pkt_o(cache_pkt_o)
  );

  ////////////////////
  // response side
  ////////////////////

  // headers wait here while their data is collected
  msg_fifo #(.WIDTH_P($bits(mem_hdr_s)), .DEPTH_P(2)) hdr_fifo (
    .clk_i(clk_i), .reset_i(reset_i),
    .data_i(cmd.hdr), .v_i(hdr_push), .ready_o(hdr_ready),
    .data_o(hdr), .v_o(hdr_v), .yumi_i(mem_resp_yumi_i)
  );

  resp_collect collect (
    .clk_i(clk_i), .reset_i(reset_i), .clearing_i(clearing),
    .hdr_i(hdr), .hdr_v_i(hdr_v), .data_i(cache_data_i), .v_i(cache_v_i),
    .resp_yumi_i(mem_resp_yumi_i), .yumi_o(cache_yumi_o),
    .resp_o(mem_resp_o), .resp_v_o(mem_resp_v_o)
  );

endmodule

// File: src/resp_collect.sv
// one beat per cache packet, in order; words beyond the response size are stale, not zeroed
`timescale 1ns/1ps

module resp_collect
  import cce_cache_pkg::*;
(
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              clearing_i,
  input  mem_hdr_s          hdr_i,
  input  logic              hdr_v_i,
  input  logic [DATA_W-1:0] data_i,
  input  logic              v_i,
  input  logic              resp_yumi_i,
  output logic              yumi_o,
  output mem_msg_s          resp_o,
  output logic              resp_v_o
);

  logic [BEAT_CNT_W-1:0] cnt_r;
  logic [BLOCK_WORDS-1:0][DATA_W-1:0] word_r;
  logic [BLOCK_WORDS-1:0] word_we;
  logic done_r, done_set, beat_take;

  // tag stores are acked during clear; otherwise stall while a response waits
  assign yumi_o    = clearing_i ? v_i : (v_i & hdr_v_i & ~done_r);
  assign beat_take = yumi_o & ~clearing_i;
  assign done_set  = beat_take & (cnt_r == last_beat(hdr_i.size));

  ////////////////////
  // beat to word decode
  ////////////////////

  always_comb begin
    for (int i = 0; i < BLOCK_WORDS; i++) begin
      word_we[i] = beat_take & (cnt_r == BEAT_CNT_W'(i));
    end
  end

  // word store
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < BLOCK_WORDS; i++) begin
      if (word_we[i]) word_r[i] <= data_i;
    end
  end

  ////////////////////
  // output
  ////////////////////

  // the arriving beat bypasses its register so valid can rise on the last beat
  always_comb begin
    resp_o.hdr = hdr_i;
    for (int i = 0; i < BLOCK_WORDS; i++) begin
      resp_o.data[i] = word_we[i] ? data_i : word_r[i];
    end
  end

  assign resp_v_o = hdr_v_i & (done_r | done_set);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_r  <= '0;
      done_r <= 1'b0;
    end else begin
      // yumi closes the response and rewinds the count
      cnt_r  <= resp_yumi_i ? '0 : cnt_r + BEAT_CNT_W'(beat_take);
      done_r <= ~resp_yumi_i & (done_r | done_set);
    end
  end

endmodule

// File: src/cache_pkt_encode.sv
// combinational; block commands are assumed aligned so base plus 8*beat stays in the block
`timescale 1ns/1ps

module cache_pkt_encode
  import cce_cache_pkg::*;
#(
  parameter int SETS_P = 64,
  parameter int WAYS_P = 8,
  localparam int IDX_W = $clog2(SETS_P * WAYS_P)
) (
  input  ctrl_state_e           state_i,
  input  mem_msg_s              cmd_i,
  input  logic [BEAT_CNT_W-1:0] beat_i,
  input  logic [IDX_W-1:0]      tag_idx_i,
  output cache_pkt_s            pkt_o
);

  cache_op_e op;

  ////////////////////
  // opcode from type and size
  ////////////////////

  always_comb begin
    if (cmd_i.hdr.msg_type == e_mem_rd) begin
      case (cmd_i.hdr.size)
        e_size_1: op = e_lb;
        e_size_2: op = e_lh;
        e_size_4: op = e_lw;
        e_size_8: op = e_ld;
        default: op = e_lm;
      endcase
    end else begin
      case (cmd_i.hdr.size)
        e_size_1: op = e_sb;
        e_size_2: op = e_sh;
        e_size_4: op = e_sw;
        e_size_8: op = e_sd;
        default: op = e_sm;
      endcase
    end
  end

  always_comb begin
    case (state_i)
      e_clear_tag: begin
        // set and way index sits above the block offset
        pkt_o.opcode = e_tagst;
        pkt_o.addr   = ADDR_W'({tag_idx_i, {BLOCK_OFFSET_W{1'b0}}});
        pkt_o.data   = '0;
        pkt_o.mask   = '0;
      end
      default: begin
        // one data word per beat
        pkt_o.opcode = op;
        pkt_o.addr   = cmd_i.hdr.addr + ADDR_W'({beat_i, {BYTE_OFFSET_W{1'b0}}});
        pkt_o.data   = cmd_i.data[beat_i];
        pkt_o.mask   = '1;
      end
    endcase
  end

endmodule

// File: src/cache_cmd_ctrl.sv
// one command in flight; header queue must have room before a command starts, SETS_P*WAYS_P >= 2
`timescale 1ns/1ps

module cache_cmd_ctrl
  import cce_cache_pkg::*;
#(
  parameter int SETS_P = 64,
  parameter int WAYS_P = 8,
  localparam int IDX_W = $clog2(SETS_P * WAYS_P)
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  mem_msg_s              cmd_i,
  input  logic                  cmd_v_i,
  input  logic                  hdr_ready_i,
  input  logic                  cache_ready_i,
  input  logic                  cache_v_i,
  output logic                  cmd_yumi_o,
  output logic                  hdr_v_o,
  output ctrl_state_e           state_o,
  output logic [BEAT_CNT_W-1:0] beat_o,
  output logic [IDX_W-1:0]      tag_idx_o,
  output logic                  cache_v_o,
  output logic                  clearing_o
);

  localparam logic [IDX_W:0] TAG_TOTAL = (IDX_W + 1)'(SETS_P * WAYS_P);

  ctrl_state_e state_r, state_n;
  // tag stores sent / data beats returned during clear
  logic [IDX_W:0] tag_sent_r, tag_recv_r;
  logic [BEAT_CNT_W-1:0] beat_r, last_beat_r;
  logic pkt_taken, last_taken;

  assign pkt_taken  = cache_v_o & cache_ready_i;
  assign last_taken = pkt_taken & (beat_r == last_beat_r);

  ////////////////////
  // next state and outputs
  ////////////////////

  always_comb begin
    state_n    = state_r;
    cache_v_o  = 1'b0;
    cmd_yumi_o = 1'b0;
    hdr_v_o    = 1'b0;
    case (state_r)
      e_reset: state_n = e_clear_tag;
      e_clear_tag: begin
        cache_v_o = (tag_sent_r != TAG_TOTAL);
        // every tag store sent and acknowledged
        if ((tag_sent_r == TAG_TOTAL) && (tag_recv_r == TAG_TOTAL)) state_n = e_ready;
      end
      e_ready: begin
        // reserve a header slot as the command starts
        if (cmd_v_i & hdr_ready_i) begin
          hdr_v_o = 1'b1;
          state_n = e_send;
        end
      end
      e_send: begin
        cache_v_o = 1'b1;
        if (last_taken) begin
          cmd_yumi_o = 1'b1;
          state_n    = e_ready;
        end
      end
      default: state_n = e_reset;
    endcase
  end

  assign state_o    = state_r;
  assign beat_o     = beat_r;
  assign tag_idx_o  = tag_sent_r[IDX_W-1:0];
  assign clearing_o = (state_r == e_clear_tag);

  ////////////////////
  // registers
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r    <= e_reset;
      tag_sent_r <= '0;
      tag_recv_r <= '0;
      beat_r     <= '0;
    end else begin
      state_r <= state_n;
      if (clearing_o && pkt_taken) tag_sent_r <= tag_sent_r + 1'b1;
      if (clearing_o && cache_v_i) tag_recv_r <= tag_recv_r + 1'b1;
      // step per accepted beat, back to zero after the last
      if (state_r == e_send && pkt_taken) beat_r <= last_taken ? '0 : beat_r + 1'b1;
    end
  end

  // last beat of the command being sent
  always_ff @(posedge clk_i) begin
    if (hdr_v_o) last_beat_r <= last_beat(cmd_i.hdr.size);
  end

endmodule

// File: src/msg_fifo.sv
// valid/ready in, valid/yumi out; yumi_i only while v_o is high, no bypass from input to output
`timescale 1ns/1ps

module msg_fifo #(
  parameter int WIDTH_P = 32,
  parameter int DEPTH_P = 2
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic [WIDTH_P-1:0] data_i,
  input  logic               v_i,
  output logic               ready_o,
  output logic [WIDTH_P-1:0] data_o,
  output logic               v_o,
  input  logic               yumi_i
);

  localparam int PTR_W = (DEPTH_P > 1) ? $clog2(DEPTH_P) : 1;

  logic [WIDTH_P-1:0] mem_r [DEPTH_P];
  logic [PTR_W-1:0] rd_ptr_r, wr_ptr_r;
  // set by a push, cleared by a pop; tells full from empty when pointers meet
  logic last_push_r;
  logic ptr_eq, push, pop;

  assign ptr_eq  = (rd_ptr_r == wr_ptr_r);
  assign ready_o = ~(ptr_eq & last_push_r);
  assign v_o     = ~(ptr_eq & ~last_push_r);
  assign push    = v_i & ready_o;
  assign pop     = yumi_i;
  assign data_o  = mem_r[rd_ptr_r];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_ptr_r    <= '0;
      wr_ptr_r    <= '0;
      last_push_r <= 1'b0;
    end else begin
      // pointers wrap at depth, not at a power of two
      if (push) wr_ptr_r <= (wr_ptr_r == PTR_W'(DEPTH_P - 1)) ? '0 : wr_ptr_r + 1'b1;
      if (pop) rd_ptr_r <= (rd_ptr_r == PTR_W'(DEPTH_P - 1)) ? '0 : rd_ptr_r + 1'b1;
      if (push != pop) last_push_r <= push;
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push) mem_r[wr_ptr_r] <= data_i;
  end

endmodule

// File: src/cce_cache_pkg.sv
// shared types for the cache bridge; 28-bit addresses, 64-bit words, 64-byte blocks, no atomics
package cce_cache_pkg;

  ////////////////////
  // widths
  ////////////////////

  // physical address and cache word
  localparam int ADDR_W = 28;
  localparam int DATA_W = 64;
  // words per block, beats per block
  localparam int BLOCK_WORDS = 8;
  localparam int BEAT_CNT_W = 3;
  // byte offset within a word, then within a block
  localparam int BYTE_OFFSET_W = 3;
  localparam int BLOCK_OFFSET_W = 6;
  localparam int MASK_W = DATA_W / 8;

  ////////////////////
  // encodings
  ////////////////////

  typedef enum logic [0:0] {e_mem_rd, e_mem_wr} mem_msg_type_e;

  // size in bytes is 1 << code
  typedef enum logic [2:0] {
    e_size_1, e_size_2, e_size_4, e_size_8, e_size_16, e_size_32, e_size_64
  } mem_msg_size_e;

  typedef enum logic [3:0] {
    e_tagst, e_lb, e_lh, e_lw, e_ld, e_lm, e_sb, e_sh, e_sw, e_sd, e_sm
  } cache_op_e;

  typedef enum logic [1:0] {e_reset, e_clear_tag, e_ready, e_send} ctrl_state_e;

  ////////////////////
  // messages
  ////////////////////

  // 32 bits
  typedef struct packed {
    mem_msg_type_e msg_type;
    mem_msg_size_e size;
    logic [ADDR_W-1:0] addr;
  } mem_hdr_s;

  // 544 bits, word 0 in the low bits
  typedef struct packed {
    mem_hdr_s hdr;
    logic [BLOCK_WORDS-1:0][DATA_W-1:0] data;
  } mem_msg_s;

  // 104 bits
  typedef struct packed {
    cache_op_e opcode;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [MASK_W-1:0] mask;
  } cache_pkt_s;

  // index of the last beat, i.e. number of beats minus one
  function automatic logic [BEAT_CNT_W-1:0] last_beat(mem_msg_size_e size);
    case (size)
      e_size_16: return BEAT_CNT_W'(1);
      e_size_32: return BEAT_CNT_W'(3);
      e_size_64: return BEAT_CNT_W'(7);
      default: return '0;
    endcase
  endfunction

endpackage
